// File: src.f
hdl/execPkg.sv
hdl/mulDivIf.sv
hdl/aluUnit.sv
hdl/mulDivCore.sv
hdl/executeStage.sv
hdl/executeTop.sv
test/executeTb.sv

// File: Bender.yml
package:
  name: execute_stage

sources:
  - hdl/execPkg.sv
  - hdl/mulDivIf.sv
  - hdl/aluUnit.sv
  - hdl/mulDivCore.sv
  - hdl/executeStage.sv
  - hdl/executeTop.sv
  - target: test
    files:
      - test/executeTb.sv

// File: test/executeTb.sv
`timescale 1ns/1ps

module executeTb;

    typedef struct {
        execPkg::srcA_e    srcA;
        execPkg::srcB_e    srcB;
        execPkg::aluOp_e   aluOp;
        execPkg::mulOp_e   mulOp;
        logic              isMulDiv;
        logic              isWord;
        logic              isSetFlag;
        execPkg::flagSel_e useFlag;
        logic              flagInv;
        logic              cmpImm;
        execPkg::csrOp_e   csrOp;
        execPkg::word_t    rs1;
        execPkg::word_t    rs2;
        execPkg::word_t    imm;
        execPkg::word_t    pc;
        execPkg::word_t    csrValue;
        execPkg::regAddr_t rd;
        logic              flush;
    } item_t;

    typedef struct {
        logic              valid;
        execPkg::word_t    result;
        logic              flag;
        execPkg::regAddr_t rd;
        execPkg::word_t    csr;
    } expect_t;

    localparam execPkg::word_t mostNeg = {1'b1, 63'b0};

    logic              clk = 1'b0;
    logic              rst;
    logic              advance;
    logic              flush;
    logic              inValid;
    execPkg::srcA_e    srcASel;
    execPkg::srcB_e    srcBSel;
    execPkg::aluOp_e   aluOp;
    execPkg::mulOp_e   mulOp;
    logic              isMulDiv;
    logic              isWord;
    logic              isSetFlag;
    execPkg::flagSel_e useFlag;
    logic              flagInv;
    logic              cmpImm;
    execPkg::csrOp_e   csrOp;
    execPkg::word_t    rs1;
    execPkg::word_t    rs2;
    execPkg::word_t    imm;
    execPkg::word_t    pc;
    execPkg::word_t    csrValue;
    execPkg::regAddr_t rd;
    logic              ready;
    logic              outValid;
    execPkg::word_t    outResult;
    logic              outFlag;
    execPkg::regAddr_t outRd;
    execPkg::word_t    outCsrValue;
    logic              fwdValid;
    execPkg::regAddr_t fwdRd;
    execPkg::word_t    fwdData;

    execPkg::word_t lcgState = 64'd77;
    expect_t        expQ[$];           // One entry per advance, in order.
    logic           checkDue = 1'b0;
    logic           hung = 1'b0;
    int             checks = 0;
    int             errors = 0;

    executeTop DUT (.*);

    always #2 clk = ~clk;

    // ==============================
    // Random numbers
    // ==============================

    function automatic execPkg::word_t lcgNext();
        lcgState = lcgState * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcgState;
    endfunction

    function automatic execPkg::word_t randWord();
        execPkg::word_t hi;
        execPkg::word_t lo;
        hi = lcgNext();
        lo = lcgNext();
        return {hi[63:32], lo[63:32]};     // Upper LCG bits are the better ones.
    endfunction

    function automatic int randBelow(input int n);
        execPkg::word_t t;
        t = lcgNext();
        return int'(t[62:32]) % n;
    endfunction

    function automatic execPkg::word_t edgeOperand();
        case (randBelow(6))
            0:       return '0;
            1:       return '1;
            2:       return mostNeg;
            3:       return execPkg::word_t'(1);
            4:       return ~mostNeg;
            default: return randWord();
        endcase
    endfunction

    function automatic item_t randomItem();
        item_t it;
        it.srcA      = execPkg::srcA_e'(randBelow(4));
        it.srcB      = execPkg::srcB_e'(randBelow(4));
        it.aluOp     = execPkg::aluOp_e'(randBelow(10));
        it.mulOp     = execPkg::mulOp_e'(randBelow(7));
        it.isMulDiv  = 1'b0;
        it.isWord    = randBelow(2) == 1;
        it.isSetFlag = 1'b0;
        it.useFlag   = execPkg::flagSel_e'(randBelow(3));
        it.flagInv   = randBelow(2) == 1;
        it.cmpImm    = randBelow(2) == 1;
        it.csrOp     = execPkg::csrOp_e'(randBelow(7));
        it.rs1       = randWord();
        it.rs2       = randWord();
        it.imm       = randWord();
        it.pc        = randWord();
        it.csrValue  = randWord();
        it.rd        = execPkg::regAddr_t'(randBelow(32));
        it.flush     = 1'b0;
        return it;
    endfunction

    function automatic item_t mulDivItem(input execPkg::mulOp_e op, input execPkg::word_t a,
                                         input execPkg::word_t b, input logic word);
        item_t it;
        it          = randomItem();
        it.isMulDiv = 1'b1;
        it.mulOp    = op;
        it.srcA     = execPkg::SRCA_RS1;
        it.srcB     = execPkg::SRCB_RS2;
        it.rs1      = a;
        it.rs2      = b;
        it.isWord   = word;
        return it;
    endfunction

    // ==============================
    // Reference model
    // ==============================

    function automatic execPkg::word_t modelAlu(input execPkg::aluOp_e op,
                                                input execPkg::word_t a, input execPkg::word_t b);
        case (op)
            execPkg::ALU_ADD:  return a + b;
            execPkg::ALU_SUB:  return a - b;
            execPkg::ALU_SLL:  return a << b[5:0];
            execPkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            execPkg::ALU_SLTU: return (a < b) ? 64'd1 : 64'd0;
            execPkg::ALU_XOR:  return a ^ b;
            execPkg::ALU_SRL:  return a >> b[5:0];
            execPkg::ALU_SRA:  return $signed(a) >>> b[5:0];
            execPkg::ALU_OR:   return a | b;
            default:           return a & b;
        endcase
    endfunction

    // Word forms work on the low 32 bits and sign-extend the outcome.
    function automatic execPkg::word_t modelWord(input execPkg::aluOp_e op,
                                                 input execPkg::word_t a, input execPkg::word_t b);
        logic [31:0] w;
        case (op)
            execPkg::ALU_ADD: w = a[31:0] + b[31:0];
            execPkg::ALU_SUB: w = a[31:0] - b[31:0];
            execPkg::ALU_SLL: w = a[31:0] << b[4:0];
            execPkg::ALU_SRL: w = a[31:0] >> b[4:0];
            default:          w = $signed(a[31:0]) >>> b[4:0];
        endcase
        return {{32{w[31]}}, w};
    endfunction

    function automatic execPkg::word_t modelMulDiv(input execPkg::mulOp_e op,
                                                   input execPkg::word_t a, input execPkg::word_t b);
        logic [127:0]   p;
        execPkg::word_t r;
        logic           overflow;
        overflow = (a == mostNeg) && (b == '1);
        case (op)
            execPkg::MD_MUL: begin
                p = {64'b0, a} * {64'b0, b};
                r = p[63:0];
            end
            execPkg::MD_MULH: begin
                p = {{64{a[63]}}, a} * {{64{b[63]}}, b};
                r = p[127:64];
            end
            execPkg::MD_MULHU: begin
                p = {64'b0, a} * {64'b0, b};
                r = p[127:64];
            end
            execPkg::MD_DIV: begin
                if (b == '0) r = '1;
                else if (overflow) r = mostNeg;
                else r = $signed(a) / $signed(b);
            end
            execPkg::MD_DIVU: begin
                if (b == '0) r = '1;
                else r = a / b;
            end
            execPkg::MD_REM: begin
                if (b == '0) r = a;
                else if (overflow) r = '0;
                else r = $signed(a) % $signed(b);
            end
            default: begin
                if (b == '0) r = a;
                else r = a % b;
            end
        endcase
        return r;
    endfunction

    function automatic expect_t modelItem(input item_t it);
        expect_t        e;
        execPkg::word_t a;
        execPkg::word_t b;
        execPkg::word_t cmpB;
        execPkg::word_t md;
        case (it.srcA)
            execPkg::SRCA_ZERO: a = '0;
            execPkg::SRCA_RS1:  a = it.rs1;
            execPkg::SRCA_PC:   a = it.pc;
            default:            a = it.pc + 64'd4;
        endcase
        case (it.srcB)
            execPkg::SRCB_RS2:      b = it.rs2;
            execPkg::SRCB_IMM:      b = it.imm;
            execPkg::SRCB_IMMUPPER: b = {it.imm[51:0], 12'b0};
            default:                b = it.csrValue;
        endcase
        cmpB = it.cmpImm ? it.imm : it.rs2;
        case (it.useFlag)
            execPkg::FLAG_LT:  e.flag = $signed(it.rs1) < $signed(cmpB);
            execPkg::FLAG_LTU: e.flag = it.rs1 < cmpB;
            default:           e.flag = it.rs1 == cmpB;
        endcase
        e.flag = e.flag ^ it.flagInv;
        case (it.csrOp)
            execPkg::CSR_RW:  e.csr = it.rs1;
            execPkg::CSR_RS:  e.csr = it.csrValue | it.rs1;
            execPkg::CSR_RC:  e.csr = it.csrValue & ~it.rs1;
            execPkg::CSR_RWI: e.csr = it.imm;
            execPkg::CSR_RSI: e.csr = it.csrValue | it.imm;
            execPkg::CSR_RCI: e.csr = it.csrValue & ~it.imm;
            default:          e.csr = '0;
        endcase
        if (it.isMulDiv) begin
            md       = modelMulDiv(it.mulOp, a, b);
            e.result = it.isWord ? {{32{md[31]}}, md[31:0]} : md;
        end else if (it.isWord && (it.aluOp inside {execPkg::ALU_ADD, execPkg::ALU_SUB,
                                                   execPkg::ALU_SLL, execPkg::ALU_SRL,
                                                   execPkg::ALU_SRA})) begin
            e.result = modelWord(it.aluOp, a, b);
        end else if (it.isSetFlag) begin
            e.result = {63'b0, e.flag};
        end else begin
            e.result = modelAlu(it.aluOp, a, b);
        end
        e.valid = !it.flush;
        e.rd    = it.rd;
        return e;
    endfunction

    // ==============================
    // Checks
    // ==============================

    task automatic compareWord(input string what, input execPkg::word_t got,
                               input execPkg::word_t want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic compareBit(input string what, input logic got, input logic want);
        checks++;
        assert (got === want) else begin
            errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    always @(posedge clk) checkDue <= advance;

    // Compares the output register one cycle after each registering edge.
    always @(negedge clk) begin
        expect_t e;
        if (checkDue) begin
            if (expQ.size() == 0) begin
                errors++;
                $display("An item was registered at %0t ns with nothing expected", $time);
            end else begin
                e = expQ.pop_front();
                compareBit("outValid", outValid, e.valid);
                if (e.valid) begin
                    compareWord("outResult", outResult, e.result);
                    compareBit("outFlag", outFlag, e.flag);
                    compareWord("outRd", 64'(outRd), 64'(e.rd));
                    compareWord("outCsrValue", outCsrValue, e.csr);
                end
            end
        end
    end

    // ==============================
    // Driver
    // ==============================

    task automatic driveItem(input item_t it);
        srcASel   <= it.srcA;
        srcBSel   <= it.srcB;
        aluOp     <= it.aluOp;
        mulOp     <= it.mulOp;
        isMulDiv  <= it.isMulDiv;
        isWord    <= it.isWord;
        isSetFlag <= it.isSetFlag;
        useFlag   <= it.useFlag;
        flagInv   <= it.flagInv;
        cmpImm    <= it.cmpImm;
        csrOp     <= it.csrOp;
        rs1       <= it.rs1;
        rs2       <= it.rs2;
        imm       <= it.imm;
        pc        <= it.pc;
        csrValue  <= it.csrValue;
        rd        <= it.rd;
        flush     <= it.flush;
        inValid   <= 1'b1;
        advance   <= 1'b0;
    endtask

    task automatic runItem(input item_t it);
        expect_t e;
        int      waited;
        if (hung) return;
        e = modelItem(it);
        @(posedge clk);
        driveItem(it);
        @(negedge clk);
        if (it.isMulDiv) compareBit("ready while mul/div runs", ready, 1'b0);
        waited = 0;
        while (!ready && waited < 200) begin
            @(negedge clk);
            waited++;
        end
        if (!ready) begin
            errors++;
            hung = 1'b1;
            $display("The multiply/divide never finished: ready stayed low for 200 cycles");
            return;
        end
        compareBit("fwdValid", fwdValid, it.rd != '0);
        compareWord("fwdRd", 64'(fwdRd), 64'(it.rd));
        compareWord("fwdData", fwdData, e.result);
        expQ.push_back(e);
        @(posedge clk);
        advance <= 1'b1;
        @(posedge clk);
        advance <= 1'b0;
        flush   <= 1'b0;
        inValid <= 1'b0;
    endtask

    // A new item with advance low must not disturb the output register.
    task automatic holdCheck();
        logic              heldValid;
        execPkg::word_t    heldResult;
        logic              heldFlag;
        execPkg::regAddr_t heldRd;
        execPkg::word_t    heldCsr;
        if (hung) return;
        @(negedge clk);
        heldValid  = outValid;
        heldResult = outResult;
        heldFlag   = outFlag;
        heldRd     = outRd;
        heldCsr    = outCsrValue;
        @(posedge clk);
        driveItem(randomItem());
        repeat (6) begin
            @(negedge clk);
            compareBit("outValid while stalled", outValid, heldValid);
            compareWord("outResult while stalled", outResult, heldResult);
            compareBit("outFlag while stalled", outFlag, heldFlag);
            compareWord("outRd while stalled", 64'(outRd), 64'(heldRd));
            compareWord("outCsrValue while stalled", outCsrValue, heldCsr);
        end
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    initial begin
        item_t it;
        rst = 1'b1;
        driveItem(randomItem());
        inValid <= 1'b0;
        flush   <= 1'b0;
        advance <= 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compareBit("outValid after reset", outValid, 1'b0);
        compareBit("ready after reset", ready, 1'b1);

        // Every pairing of operand sources, 64-bit and word forms.
        for (int i = 0; i < 64; i++) begin
            it      = randomItem();
            it.srcA = execPkg::srcA_e'(i % 4);
            it.srcB = execPkg::srcB_e'((i / 4) % 4);
            if (i % 8 == 0) it.rd = '0;
            runItem(it);
        end

        repeat (48) begin
            it           = randomItem();
            it.isSetFlag = 1'b1;
            it.isWord    = 1'b0;
            it.rs1       = edgeOperand();
            it.rs2       = (randBelow(4) == 0) ? it.rs1 : edgeOperand();
            it.imm       = (randBelow(4) == 0) ? it.rs1 : edgeOperand();
            runItem(it);
        end

        for (int c = 0; c < 7; c++) begin
            it       = randomItem();
            it.csrOp = execPkg::csrOp_e'(c);
            runItem(it);
        end

        // Random, edge, divide-by-zero and overflow operands for each operation.
        for (int op = 0; op < 7; op++) begin
            runItem(mulDivItem(execPkg::mulOp_e'(op), randWord(), randWord(), 1'b0));
            runItem(mulDivItem(execPkg::mulOp_e'(op), edgeOperand(), edgeOperand(), 1'b0));
            runItem(mulDivItem(execPkg::mulOp_e'(op), edgeOperand(), edgeOperand(), 1'b0));
            runItem(mulDivItem(execPkg::mulOp_e'(op), randWord(), '0, 1'b0));
            runItem(mulDivItem(execPkg::mulOp_e'(op), mostNeg, '1, 1'b0));
        end
        runItem(mulDivItem(execPkg::MD_MUL, randWord(), randWord(), 1'b1));
        runItem(mulDivItem(execPkg::MD_MUL, edgeOperand(), randWord(), 1'b1));

        holdCheck();
        it       = randomItem();
        it.flush = 1'b1;
        runItem(it);
        runItem(randomItem());

        repeat (3) @(posedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: hdl/executeTop.sv
`timescale 1ns/1ps

module executeTop (
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,
    input  logic              flush,
    input  logic              inValid,
    input  execPkg::srcA_e    srcASel,
    input  execPkg::srcB_e    srcBSel,
    input  execPkg::aluOp_e   aluOp,
    input  execPkg::mulOp_e   mulOp,
    input  logic              isMulDiv,
    input  logic              isWord,
    input  logic              isSetFlag,
    input  execPkg::flagSel_e useFlag,
    input  logic              flagInv,
    input  logic              cmpImm,
    input  execPkg::csrOp_e   csrOp,
    input  execPkg::word_t    rs1,
    input  execPkg::word_t    rs2,
    input  execPkg::word_t    imm,
    input  execPkg::word_t    pc,
    input  execPkg::word_t    csrValue,
    input  execPkg::regAddr_t rd,
    output logic              ready,
    output logic              outValid,
    output execPkg::word_t    outResult,
    output logic              outFlag,
    output execPkg::regAddr_t outRd,
    output execPkg::word_t    outCsrValue,
    output logic              fwdValid,
    output execPkg::regAddr_t fwdRd,
    output execPkg::word_t    fwdData
);

    execPkg::word_t                aluA;
    execPkg::word_t                aluB;
    execPkg::word_t                aluResult;
    logic [execPkg::halfWidth-1:0] aluResultWord;

    mulDivIf mdBus ();

    // Names match the stage ports one for one.
    executeStage stage (
        .*,
        .mdu (mdBus.stage)
    );

    aluUnit alu (
        .a          (aluA),
        .b          (aluB),
        .op         (aluOp),
        .result     (aluResult),
        .resultWord (aluResultWord)
    );

    mulDivCore mdu (
        .clk (clk),
        .rst (rst),
        .mdu (mdBus.unit)
    );

endmodule

// File: hdl/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          advance,
    input  logic                          flush,
    input  logic                          inValid,
    input  execPkg::srcA_e                srcASel,
    input  execPkg::srcB_e                srcBSel,
    input  execPkg::aluOp_e               aluOp,
    input  execPkg::mulOp_e               mulOp,
    input  logic                          isMulDiv,
    input  logic                          isWord,
    input  logic                          isSetFlag,
    input  execPkg::flagSel_e             useFlag,
    input  logic                          flagInv,
    input  logic                          cmpImm,
    input  execPkg::csrOp_e               csrOp,
    input  execPkg::word_t                rs1,
    input  execPkg::word_t                rs2,
    input  execPkg::word_t                imm,
    input  execPkg::word_t                pc,
    input  execPkg::word_t                csrValue,
    input  execPkg::regAddr_t             rd,
    input  execPkg::word_t                aluResult,
    input  logic [execPkg::halfWidth-1:0] aluResultWord,
    mulDivIf.stage                        mdu,
    output execPkg::word_t                aluA,
    output execPkg::word_t                aluB,
    output logic                          ready,
    output logic                          outValid,
    output execPkg::word_t                outResult,
    output logic                          outFlag,
    output execPkg::regAddr_t             outRd,
    output execPkg::word_t                outCsrValue,
    output logic                          fwdValid,
    output execPkg::regAddr_t             fwdRd,
    output execPkg::word_t                fwdData
);

    localparam int hw = execPkg::halfWidth;

    execPkg::word_t cmpB;
    logic           flag;
    logic           wordOp;
    logic           submitted;
    execPkg::word_t csrWrite;
    execPkg::word_t result;

    always_comb begin
        case (srcASel)
            execPkg::SRCA_ZERO: aluA = '0;
            execPkg::SRCA_RS1:  aluA = rs1;
            execPkg::SRCA_PC:   aluA = pc;
            default:            aluA = pc + execPkg::word_t'(4);
        endcase
        case (srcBSel)
            execPkg::SRCB_RS2:      aluB = rs2;
            execPkg::SRCB_IMM:      aluB = imm;
            execPkg::SRCB_IMMUPPER: aluB = imm << 12;
            default:                aluB = csrValue;
        endcase
    end

    // Compare flags for set-less-than and branches.
    assign cmpB = cmpImm ? imm : rs2;
    always_comb begin
        case (useFlag)
            execPkg::FLAG_LT:  flag = $signed(rs1) < $signed(cmpB);
            execPkg::FLAG_LTU: flag = rs1 < cmpB;
            execPkg::FLAG_EQ:  flag = rs1 == cmpB;
            default:           flag = 1'b0;
        endcase
        flag = flag ^ flagInv;
    end

    always_comb begin
        case (csrOp)
            execPkg::CSR_RW:  csrWrite = rs1;
            execPkg::CSR_RS:  csrWrite = csrValue | rs1;
            execPkg::CSR_RC:  csrWrite = csrValue & ~rs1;
            execPkg::CSR_RWI: csrWrite = imm;
            execPkg::CSR_RSI: csrWrite = csrValue | imm;
            execPkg::CSR_RCI: csrWrite = csrValue & ~imm;
            default:          csrWrite = '0;
        endcase
    end

    // ==============================
    // Result selection
    // ==============================

    // RV64 has word forms only for add, subtract and the shifts.
    assign wordOp = isWord && (aluOp inside {execPkg::ALU_ADD, execPkg::ALU_SUB,
                                             execPkg::ALU_SLL, execPkg::ALU_SRL,
                                             execPkg::ALU_SRA});

    always_comb begin
        if (isMulDiv) begin
            result = isWord ? {{hw{mdu.result[hw-1]}}, mdu.result[hw-1:0]} : mdu.result;
        end else if (wordOp) begin
            result = {{hw{aluResultWord[hw-1]}}, aluResultWord};
        end else if (isSetFlag) begin
            result = execPkg::word_t'(flag);
        end else begin
            result = aluResult;
        end
    end

    assign fwdValid = inValid && (rd != '0);
    assign fwdRd    = rd;
    assign fwdData  = result;

    // ==============================
    // Multiply/divide handshake and output register
    // ==============================

    assign mdu.start = inValid && isMulDiv && !submitted && !mdu.busy;
    assign mdu.op    = mulOp;
    assign mdu.a     = aluA;
    assign mdu.b     = aluB;

    assign ready = !(inValid && isMulDiv && !(submitted && mdu.done));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outValid  <= 1'b0;
            submitted <= 1'b0;
        end else if (advance) begin
            outValid  <= inValid && !flush;
            submitted <= 1'b0;
        end else if (mdu.start) begin
            submitted <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            outResult   <= result;
            outFlag     <= flag;
            outRd       <= rd;
            outCsrValue <= csrWrite;
        end
    end

endmodule

// File: hdl/mulDivCore.sv
`timescale 1ns/1ps

module mulDivCore (
    input logic   clk,
    input logic   rst,
    mulDivIf.unit mdu
);

    localparam int msb = execPkg::dataWidth - 1;

    typedef enum logic [1:0] {IDLE, RUN, FIX, DONE} state_e;

    state_e                             state;
    logic [execPkg::shiftWidth-1:0]     count;
    execPkg::mulOp_e                    op;
    logic                               negate;
    logic                               isMul;
    logic                               accept;
    execPkg::word_t                     accHi;     // Product high half or partial remainder.
    execPkg::word_t                     accLo;     // Multiplier bits or dividend/quotient bits.
    execPkg::word_t                     opB;       // Multiplicand or divisor.
    logic [execPkg::dataWidth:0]        mulSum;
    logic [execPkg::dataWidth:0]        divTrial;
    logic [execPkg::dataWidth:0]        divDiff;
    logic                               divFits;
    logic [2*execPkg::dataWidth-1:0]    productFixed;
    execPkg::word_t                     fixResult;
    logic                               aSigned;
    logic                               bSigned;
    logic                               startIsMul;
    logic                               startZeroDiv;
    execPkg::word_t                     magA;
    execPkg::word_t                     magB;
    logic                               negNext;

    assign accept    = mdu.start && (state == IDLE || state == DONE);
    assign isMul     = op inside {execPkg::MD_MUL, execPkg::MD_MULH, execPkg::MD_MULHU};
    assign mdu.busy  = (state == RUN) || (state == FIX);
    assign mdu.done  = (state == DONE);

    // ==============================
    // Request decode
    // ==============================

    always_comb begin
        aSigned      = mdu.op inside {execPkg::MD_MULH, execPkg::MD_DIV, execPkg::MD_REM};
        bSigned      = mdu.op inside {execPkg::MD_MULH, execPkg::MD_DIV, execPkg::MD_REM};
        startIsMul   = mdu.op inside {execPkg::MD_MUL, execPkg::MD_MULH, execPkg::MD_MULHU};
        startZeroDiv = !startIsMul && (mdu.b == '0);
        // A zero divisor keeps the raw dividend so the remainder comes out unchanged.
        magA = (aSigned && mdu.a[msb] && !startZeroDiv) ? -mdu.a : mdu.a;
        magB = (bSigned && mdu.b[msb]) ? -mdu.b : mdu.b;
        case (mdu.op)
            execPkg::MD_MULH, execPkg::MD_DIV: negNext = mdu.a[msb] ^ mdu.b[msb];
            execPkg::MD_REM:                   negNext = mdu.a[msb];
            default:                           negNext = 1'b0;
        endcase
    end

    // ==============================
    // Datapath steps
    // ==============================

    assign mulSum   = {1'b0, accHi} + (accLo[0] ? {1'b0, opB} : '0);
    assign divTrial = {accHi, accLo[msb]};
    assign divDiff  = divTrial - {1'b0, opB};
    assign divFits  = divTrial >= {1'b0, opB};

    assign productFixed = negate ? -{accHi, accLo} : {accHi, accLo};

    always_comb begin
        case (op)
            execPkg::MD_MUL:                     fixResult = accLo;
            execPkg::MD_MULH, execPkg::MD_MULHU:
                fixResult = productFixed[2*execPkg::dataWidth-1:execPkg::dataWidth];
            execPkg::MD_DIV, execPkg::MD_DIVU:   fixResult = (negate && !mdu.divZero) ? -accLo : accLo;
            default:                             fixResult = (negate && !mdu.divZero) ? -accHi : accHi;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= IDLE;
            count       <= '0;
            mdu.divZero <= 1'b0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (accept) begin
                        state       <= RUN;
                        count       <= '0;
                        mdu.divZero <= startZeroDiv;
                    end
                end
                RUN: begin
                    count <= count + 1'b1;
                    if (count == '1) begin
                        state <= FIX;
                    end
                end
                default: state <= DONE;     // FIX takes a single cycle.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op     <= mdu.op;
            negate <= negNext;
            accHi  <= '0;
            accLo  <= startIsMul ? magB : magA;
            opB    <= startIsMul ? magA : magB;
        end else if (state == RUN) begin
            if (isMul) begin
                {accHi, accLo} <= {mulSum, accLo[msb:1]};
            end else begin
                accHi <= divFits ? divDiff[msb:0] : divTrial[msb:0];
                accLo <= {accLo[msb-1:0], divFits};
            end
        end else if (state == FIX) begin
            mdu.result <= fixResult;
        end
    end

endmodule

// File: hdl/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  execPkg::word_t                a,
    input  execPkg::word_t                b,
    input  execPkg::aluOp_e               op,
    output execPkg::word_t                result,
    output logic [execPkg::halfWidth-1:0] resultWord
);

    logic [execPkg::shiftWidth-1:0] shamt;
    logic [4:0]                     shamtWord;
    logic [execPkg::halfWidth-1:0]  aLow;
    logic [execPkg::halfWidth-1:0]  bLow;

    assign shamt     = b[execPkg::shiftWidth-1:0];
    assign shamtWord = b[4:0];
    assign aLow      = a[execPkg::halfWidth-1:0];
    assign bLow      = b[execPkg::halfWidth-1:0];

    // ==============================
    // 64-bit result
    // ==============================

    always_comb begin
        case (op)
            execPkg::ALU_ADD:  result = a + b;
            execPkg::ALU_SUB:  result = a - b;
            execPkg::ALU_SLL:  result = a << shamt;
            execPkg::ALU_SLT:  result = execPkg::word_t'($signed(a) < $signed(b));
            execPkg::ALU_SLTU: result = execPkg::word_t'(a < b);
            execPkg::ALU_XOR:  result = a ^ b;
            execPkg::ALU_SRL:  result = a >> shamt;
            execPkg::ALU_SRA:  result = $signed(a) >>> shamt;
            execPkg::ALU_OR:   result = a | b;
            execPkg::ALU_AND:  result = a & b;
            default:           result = '0;
        endcase
    end

    // ==============================
    // Word result
    // ==============================

    // Only the forms that have a W variant in RV64 differ from the low half.
    always_comb begin
        case (op)
            execPkg::ALU_ADD: resultWord = aLow + bLow;
            execPkg::ALU_SUB: resultWord = aLow - bLow;
            execPkg::ALU_SLL: resultWord = aLow << shamtWord;
            execPkg::ALU_SRL: resultWord = aLow >> shamtWord;
            execPkg::ALU_SRA: resultWord = $signed(aLow) >>> shamtWord;  // Sign from bit 31.
            default:          resultWord = result[execPkg::halfWidth-1:0];
        endcase
    end

endmodule

// File: hdl/mulDivIf.sv
`timescale 1ns/1ps

interface mulDivIf;

    logic            start;     // One-cycle request pulse.
    execPkg::mulOp_e op;
    execPkg::word_t  a;
    execPkg::word_t  b;

    logic            busy;
    logic            done;      // Level, held until the next accepted start.
    execPkg::word_t  result;
    logic            divZero;

    modport stage (
        output start, op, a, b,
        input  busy, done, result, divZero
    );

    modport unit (
        input  start, op, a, b,
        output busy, done, result, divZero
    );

endinterface

// File: hdl/execPkg.sv
package execPkg;

    // ==============================
    // Widths and data types
    // ==============================

    localparam int dataWidth  = 64;
    localparam int halfWidth  = 32;                 // Width of the RV64 word forms.
    localparam int shiftWidth = $clog2(dataWidth);

    typedef logic [dataWidth-1:0] word_t;
    typedef logic [4:0]           regAddr_t;

    // ==============================
    // Operation encodings
    // ==============================

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } aluOp_e;

    typedef enum logic [2:0] {
        MD_MUL,
        MD_MULH,
        MD_MULHU,
        MD_DIV,
        MD_DIVU,
        MD_REM,
        MD_REMU
    } mulOp_e;

    // Operand sources for the ALU and the multiply/divide unit.
    typedef enum logic [1:0] {
        SRCA_ZERO,
        SRCA_RS1,
        SRCA_PC,
        SRCA_PCPLUS4
    } srcA_e;

    typedef enum logic [1:0] {
        SRCB_RS2,
        SRCB_IMM,
        SRCB_IMMUPPER,     // Immediate shifted left by 12.
        SRCB_CSRVAL
    } srcB_e;

    typedef enum logic [2:0] {
        CSR_NONE,
        CSR_RW,
        CSR_RS,
        CSR_RC,
        CSR_RWI,
        CSR_RSI,
        CSR_RCI
    } csrOp_e;

    typedef enum logic [1:0] {
        FLAG_LT,
        FLAG_LTU,
        FLAG_EQ
    } flagSel_e;

endpackage
